// ==== src/isa_pkg.sv ====
package isa_pkg;

    localparam int INSTR_W = 18;

    // Field positions inside one instruction word
    localparam int OPCODE_MSB = 17;
    localparam int OPCODE_LSB = 14;
    localparam int R1_LSB = 10;
    localparam int R2_LSB = 6;
    localparam int R3_LSB = 2;
    localparam int IMM_W = 6;         // Immediate sits in bits 5:0
    localparam int JUMP_TGT_LSB = 4;  // Jump target sits in bits 13:4

    typedef enum logic [OPCODE_MSB-OPCODE_LSB:0] {
        OP_ADD     = 4'b0000,
        OP_ADDI    = 4'b0001,
        OP_NOR     = 4'b0010,
        OP_CMP     = 4'b0011,
        OP_AND     = 4'b0100,
        OP_ANDI    = 4'b0101,
        OP_NAND    = 4'b0110,
        OP_ILLEGAL = 4'b0111,  // No effect
        OP_LD      = 4'b1000,
        OP_ST      = 4'b1001,
        OP_JE      = 4'b1010,  // Zero and not carry
        OP_JA      = 4'b1011,  // Neither flag
        OP_JB      = 4'b1100,  // Carry and not zero
        OP_JAE     = 4'b1101,  // Not carry
        OP_JBE     = 4'b1110,  // Carry or zero
        OP_JUMP    = 4'b1111   // Unconditional
    } opcode_e;

endpackage

// ==== src/core_pkg.sv ====
package core_pkg;

    localparam int WORD_W = 18;
    localparam int ADDR_W = 10;      // PC and data memory address
    localparam int REG_ADDR_W = 4;
    localparam int NUM_REGS = 16;

    typedef enum logic [3:0] {
        S_INIT   = 4'd0,
        S_FETCH  = 4'd1,
        S_DECODE = 4'd2,
        S_ALU    = 4'd3,
        S_CMP    = 4'd4,
        S_LD     = 4'd5,
        S_ST     = 4'd6,
        S_JUMP   = 4'd7,
        S_WRITE  = 4'd8
    } state_e;

    typedef enum logic [1:0] {
        ALU_ADD  = 2'b00,
        ALU_NOR  = 2'b01,
        ALU_AND  = 2'b10,
        ALU_NAND = 2'b11
    } alu_op_e;

endpackage

// ==== src/ctrl_if.sv ====
`timescale 1ns/10ps

interface ctrl_if;
    import core_pkg::*;

    alu_op_e alu_op;
    logic    use_imm;      // Second operand is the immediate
    logic    reg_we;
    logic    flag_we;
    logic    wb_from_mem;  // Write back load data instead of ALU result
    logic    zero_flag;
    logic    carry_flag;

    modport control (
        output alu_op,
        output use_imm,
        output reg_we,
        output flag_we,
        output wb_from_mem,
        input  zero_flag,
        input  carry_flag
    );

    modport datapath (
        input  alu_op,
        input  use_imm,
        input  flag_we,
        input  wb_from_mem,
        output zero_flag,
        output carry_flag
    );

endinterface

// ==== src/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ir_load,
    input  logic                        pc_load,
    input  logic [isa_pkg::INSTR_W-1:0] instr_data,
    output logic [core_pkg::ADDR_W-1:0] pc,
    output logic [isa_pkg::INSTR_W-1:0] ir
);
    import core_pkg::*;
    import isa_pkg::*;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= ir[JUMP_TGT_LSB +: ADDR_W];  // Jump target field
        end else if (ir_load) begin
            pc <= pc + 1'b1;  // Wraps at 1024
        end
    end

    // Holds the instruction for the rest of its cycles
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= instr_data;
        end
    end

endmodule

// ==== src/control_fsm.sv ====
`timescale 1ns/10ps

module control_fsm (
    input  logic             clk,
    input  logic             reset,
    input  isa_pkg::opcode_e opcode,
    output logic             ir_load,
    output logic             pc_load,
    output logic             mem_we,
    output logic             mem_re,
    ctrl_if.control          ctrl
);
    import core_pkg::*;
    import isa_pkg::*;

    state_e state;
    state_e next_state;
    logic   is_alu;
    logic   jump_taken;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_INIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_INIT:   next_state = S_FETCH;
            S_FETCH:  next_state = S_DECODE;
            S_DECODE: begin
                case (opcode)
                    OP_ADD, OP_ADDI, OP_NOR, OP_AND, OP_ANDI, OP_NAND: begin
                        next_state = S_ALU;
                    end
                    OP_CMP:  next_state = S_CMP;
                    OP_LD:   next_state = S_LD;
                    OP_ST:   next_state = S_ST;
                    OP_JE, OP_JA, OP_JB, OP_JAE, OP_JBE, OP_JUMP: begin
                        next_state = S_JUMP;
                    end
                    default: next_state = S_WRITE;  // Illegal opcode does nothing
                endcase
            end
            S_ALU, S_CMP, S_LD, S_ST, S_JUMP: begin
                next_state = S_WRITE;
            end
            default:  next_state = S_INIT;  // WRITE ends the instruction
        endcase
    end

    // Opcode decode
    always_comb begin
        is_alu = 1'b0;
        ctrl.alu_op = ALU_ADD;
        case (opcode)
            OP_ADD, OP_ADDI: begin
                is_alu = 1'b1;
                ctrl.alu_op = ALU_ADD;
            end
            OP_NOR: begin
                is_alu = 1'b1;
                ctrl.alu_op = ALU_NOR;
            end
            OP_AND, OP_ANDI: begin
                is_alu = 1'b1;
                ctrl.alu_op = ALU_AND;
            end
            OP_NAND: begin
                is_alu = 1'b1;
                ctrl.alu_op = ALU_NAND;
            end
            default: begin
                is_alu = 1'b0;
                ctrl.alu_op = ALU_ADD;
            end
        endcase
    end

    assign ctrl.use_imm     = (opcode == OP_ADDI) || (opcode == OP_ANDI);
    assign ctrl.wb_from_mem = (opcode == OP_LD);

    always_comb begin
        case (opcode)
            OP_JE:   jump_taken = ctrl.zero_flag && !ctrl.carry_flag;
            OP_JA:   jump_taken = !ctrl.zero_flag && !ctrl.carry_flag;
            OP_JB:   jump_taken = ctrl.carry_flag && !ctrl.zero_flag;
            OP_JAE:  jump_taken = !ctrl.carry_flag;
            OP_JBE:  jump_taken = ctrl.carry_flag || ctrl.zero_flag;
            OP_JUMP: jump_taken = 1'b1;
            default: jump_taken = 1'b0;
        endcase
    end

    // One-cycle strobes per state
    assign ir_load      = (state == S_FETCH);
    assign mem_re       = (state == S_LD);
    assign mem_we       = (state == S_ST);
    assign pc_load      = (state == S_JUMP) && jump_taken;
    assign ctrl.reg_we  = (state == S_WRITE) && (is_alu || opcode == OP_LD);
    assign ctrl.flag_we = (state == S_WRITE) && (opcode == OP_CMP);

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/10ps

module register_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            we,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [core_pkg::WORD_W-1:0]     wdata,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr_c,
    output logic [core_pkg::WORD_W-1:0]     rdata_a,
    output logic [core_pkg::WORD_W-1:0]     rdata_b,
    output logic [core_pkg::WORD_W-1:0]     rdata_c
);
    import core_pkg::*;

    logic [WORD_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational read ports
    assign rdata_a = regs[raddr_a];  // R1
    assign rdata_b = regs[raddr_b];  // R2
    assign rdata_c = regs[raddr_c];  // R3

endmodule

// ==== src/execute_unit.sv ====
`timescale 1ns/10ps

module execute_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [core_pkg::WORD_W-1:0] r1_data,
    input  logic [core_pkg::WORD_W-1:0] r2_data,
    input  logic [core_pkg::WORD_W-1:0] r3_data,
    input  logic [isa_pkg::IMM_W-1:0]   imm,
    input  logic [core_pkg::WORD_W-1:0] mem_rdata,
    output logic [core_pkg::WORD_W-1:0] wb_data,
    ctrl_if.datapath                    ctrl
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [WORD_W-1:0] operand_b;
    logic [WORD_W-1:0] alu_result;
    logic              cmp_equal;
    logic              cmp_below;
    logic              zero_q;
    logic              carry_q;

    // Immediate is zero-extended
    assign operand_b = ctrl.use_imm ? {{(WORD_W-IMM_W){1'b0}}, imm} : r3_data;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  alu_result = r2_data + operand_b;  // Carry out dropped
            ALU_NOR:  alu_result = ~(r2_data | operand_b);
            ALU_AND:  alu_result = r2_data & operand_b;
            ALU_NAND: alu_result = ~(r2_data & operand_b);
            default:  alu_result = r2_data + operand_b;
        endcase
    end

    // Unsigned compare of R1 against R2
    assign cmp_equal = (r1_data == r2_data);
    assign cmp_below = (r1_data < r2_data);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            zero_q  <= 1'b0;
            carry_q <= 1'b0;
        end else if (ctrl.flag_we) begin
            zero_q  <= cmp_equal;
            carry_q <= cmp_below;
        end
    end

    assign ctrl.zero_flag  = zero_q;
    assign ctrl.carry_flag = carry_q;

    assign wb_data = ctrl.wb_from_mem ? mem_rdata : alu_result;

endmodule

// ==== src/cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top (
    input  logic                        clk,
    input  logic                        reset,
    output logic [core_pkg::ADDR_W-1:0] instr_addr,
    input  logic [isa_pkg::INSTR_W-1:0] instr_data,
    output logic [core_pkg::ADDR_W-1:0] mem_addr,
    output logic [core_pkg::WORD_W-1:0] mem_wdata,
    output logic                        mem_we,
    output logic                        mem_re,
    input  logic [core_pkg::WORD_W-1:0] mem_rdata
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [INSTR_W-1:0]    ir;
    logic                  ir_load;
    logic                  pc_load;
    opcode_e               opcode;
    logic [REG_ADDR_W-1:0] r1_addr;
    logic [REG_ADDR_W-1:0] r2_addr;
    logic [REG_ADDR_W-1:0] r3_addr;
    logic [IMM_W-1:0]      imm;
    logic [WORD_W-1:0]     r1_data;
    logic [WORD_W-1:0]     r2_data;
    logic [WORD_W-1:0]     r3_data;
    logic [WORD_W-1:0]     wb_data;

    ctrl_if ctrl ();

    // Instruction fields
    assign opcode   = opcode_e'(ir[OPCODE_MSB:OPCODE_LSB]);
    assign r1_addr  = ir[R1_LSB +: REG_ADDR_W];
    assign r2_addr  = ir[R2_LSB +: REG_ADDR_W];
    assign r3_addr  = ir[R3_LSB +: REG_ADDR_W];
    assign imm      = ir[IMM_W-1:0];
    assign mem_addr = ir[ADDR_W-1:0];

    assign mem_wdata = r1_data;  // ST source is R1

    fetch_unit i_fetch_unit (
        .clk        (clk),
        .reset      (reset),
        .ir_load    (ir_load),
        .pc_load    (pc_load),
        .instr_data (instr_data),
        .pc         (instr_addr),
        .ir         (ir)
    );

    control_fsm i_control_fsm (
        .clk     (clk),
        .reset   (reset),
        .opcode  (opcode),
        .ir_load (ir_load),
        .pc_load (pc_load),
        .mem_we  (mem_we),
        .mem_re  (mem_re),
        .ctrl    (ctrl.control)
    );

    register_file i_register_file (
        .clk     (clk),
        .reset   (reset),
        .we      (ctrl.reg_we),
        .waddr   (r1_addr),
        .wdata   (wb_data),
        .raddr_a (r1_addr),
        .raddr_b (r2_addr),
        .raddr_c (r3_addr),
        .rdata_a (r1_data),
        .rdata_b (r2_data),
        .rdata_c (r3_data)
    );

    execute_unit i_execute_unit (
        .clk       (clk),
        .reset     (reset),
        .r1_data   (r1_data),
        .r2_data   (r2_data),
        .r3_data   (r3_data),
        .imm       (imm),
        .mem_rdata (mem_rdata),
        .wb_data   (wb_data),
        .ctrl      (ctrl.datapath)
    );

endmodule

// ==== verif/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// One right shift of a 32-bit Galois LFSR
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 32'h80200003;
    end
    return n;
endfunction

task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_next(lfsr);
        v = {v[30:0], lfsr[0]};  // One step per bit
    end
endtask

// Random program, memory fill and model reset state
task automatic init_model();
    logic [31:0] op;
    logic [31:0] rest;
    lfsr = 32'hdd7f;
    for (int a = 0; a < 1024; a++) begin
        op = 32'd7;
        while (op == 32'd7) begin
            draw_bits(4, op);  // Redraw the illegal opcode
        end
        draw_bits(14, rest);
        prog[a] = {op[3:0], rest[13:0]};
        ram[a] = {~a[7:0], a[9:0]};  // Covers all ten address bits
        m_dmem[a] = {~a[7:0], a[9:0]};
    end
    for (int r = 0; r < NUM_REGS; r++) begin
        m_regs[r] = '0;
    end
    m_pc = '0;
    m_zero = 1'b0;
    m_carry = 1'b0;
    exp_st = 1'b0;
    exp_ld = 1'b0;
endtask

// Executes the instruction at the model PC
task automatic model_step();
    logic [INSTR_W-1:0] instr;
    opcode_e            op;
    logic [3:0]         r1;
    logic [3:0]         r2;
    logic [WORD_W-1:0]  b;
    logic               taken;
    instr = prog[m_pc];
    op = opcode_e'(instr[17:14]);
    r1 = instr[13:10];
    r2 = instr[9:6];
    b = instr[14] ? {12'd0, instr[5:0]} : m_regs[instr[5:2]];
    exp_st = 1'b0;
    exp_ld = 1'b0;
    exp_addr = instr[9:0];
    exp_wdata = m_regs[r1];
    taken = 1'b0;
    case (op)
        OP_ADD, OP_ADDI: m_regs[r1] = m_regs[r2] + b;
        OP_NOR:          m_regs[r1] = ~(m_regs[r2] | b);
        OP_AND, OP_ANDI: m_regs[r1] = m_regs[r2] & b;
        OP_NAND:         m_regs[r1] = ~(m_regs[r2] & b);
        OP_CMP: begin
            m_zero = (m_regs[r1] == m_regs[r2]);
            m_carry = (m_regs[r1] < m_regs[r2]);
        end
        OP_LD: begin
            exp_ld = 1'b1;
            m_regs[r1] = m_dmem[instr[9:0]];
        end
        OP_ST: begin
            exp_st = 1'b1;
            m_dmem[instr[9:0]] = m_regs[r1];
        end
        OP_JE:   taken = m_zero && !m_carry;
        OP_JA:   taken = !m_zero && !m_carry;
        OP_JB:   taken = m_carry && !m_zero;
        OP_JAE:  taken = !m_carry;
        OP_JBE:  taken = m_carry || m_zero;
        OP_JUMP: taken = 1'b1;
        default: taken = 1'b0;
    endcase
    m_pc = taken ? instr[13:4] : m_pc + 10'd1;
endtask

`endif

// ==== verif/tb_cpu.sv ====
`timescale 1ns/10ps

module tb_cpu;
    import core_pkg::*;
    import isa_pkg::*;

    localparam int NUM_INSTR = 400;
    localparam int RESET_CYCLES = 10;
    localparam int CYCLE_LIMIT = NUM_INSTR * 5 + RESET_CYCLES + 90;

    logic               clk;
    logic               reset;
    logic [ADDR_W-1:0]  instr_addr;
    logic [INSTR_W-1:0] instr_data;
    logic [ADDR_W-1:0]  mem_addr;
    logic [WORD_W-1:0]  mem_wdata;
    logic               mem_we;
    logic               mem_re;
    logic [WORD_W-1:0]  mem_rdata;

    logic [INSTR_W-1:0] prog [1024];
    logic [WORD_W-1:0]  ram [1024];     // Data RAM seen by the DUT
    logic [WORD_W-1:0]  m_dmem [1024];  // Model copy
    logic [WORD_W-1:0]  m_regs [NUM_REGS];
    logic [ADDR_W-1:0]  m_pc;
    logic               m_zero;
    logic               m_carry;
    logic               exp_st;
    logic               exp_ld;
    logic [ADDR_W-1:0]  exp_addr;
    logic [WORD_W-1:0]  exp_wdata;
    logic [31:0]        lfsr;
    int                 errors;
    int                 cycle_count;

    `include "tb_model.svh"

    cpu_top i_cpu_top (
        .clk        (clk),
        .reset      (reset),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we),
        .mem_re     (mem_re),
        .mem_rdata  (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    endtask

    initial begin
        logic              exp_we;
        logic              exp_re;
        logic              rd_pending;
        logic [ADDR_W-1:0] rd_addr;
        int                phase;
        int                instr_count;
        reset = 1'b1;
        instr_data = '0;
        mem_rdata = '0;
        rd_pending = 1'b0;
        rd_addr = '0;
        errors = 0;
        instr_count = 0;
        init_model();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (mem_we !== 1'b0) report_mismatch("mem_we", mem_we, 0);
            if (mem_re !== 1'b0) report_mismatch("mem_re", mem_re, 0);
            if (instr_addr !== '0) report_mismatch("instr_addr", instr_addr, 0);
        end
        reset = 1'b0;
        for (int cyc = 1; cyc <= NUM_INSTR * 5; cyc++) begin
            @(negedge clk);
            phase = cyc % 5;
            if (phase == 1) begin  // Fetch cycle
                if (instr_addr !== m_pc) report_mismatch("instr_addr", instr_addr, m_pc);
                model_step();
                instr_count++;
            end
            exp_we = (phase == 3) && exp_st;  // Execute cycle
            exp_re = (phase == 3) && exp_ld;
            if (mem_we !== exp_we) report_mismatch("mem_we", mem_we, exp_we);
            if (mem_re !== exp_re) report_mismatch("mem_re", mem_re, exp_re);
            if ((exp_we || exp_re) && mem_addr !== exp_addr) begin
                report_mismatch("mem_addr", mem_addr, exp_addr);
            end
            if (exp_we && mem_wdata !== exp_wdata) begin
                report_mismatch("mem_wdata", mem_wdata, exp_wdata);
            end
            // Memory models answer on the falling edge
            if (mem_we === 1'b1) ram[mem_addr] = mem_wdata;
            if (rd_pending) mem_rdata = ram[rd_addr];  // One cycle after the read strobe
            rd_pending = (mem_re === 1'b1);
            rd_addr = mem_addr;
            instr_data = prog[instr_addr];
        end
        $display("Instructions: %0d, errors: %0d", instr_count, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run did not finish within %0d cycles, errors: %0d", CYCLE_LIMIT, errors);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+verif
src/isa_pkg.sv
src/core_pkg.sv
src/ctrl_if.sv
src/fetch_unit.sv
src/control_fsm.sv
src/register_file.sv
src/execute_unit.sv
src/cpu_top.sv
verif/tb_cpu.sv
